// File: design/fetch_pkg.sv
// fetch subsystem package
// shared sizes, bus channel structs and FSM encodings

package fetch_pkg;

  localparam int unsigned rom_words = 64;
  localparam logic [31:0] reset_pc  = 32'h0000_0000;
  localparam logic [31:0] nop_insn  = 32'h0000_0013;  // addi x0,x0,0

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  typedef enum logic [6:0] {
    op_jal    = 7'b1101111,
    op_branch = 7'b1100011
  } opcode_e;

  typedef enum logic [1:0] {f_idle, f_req, f_wait} fetch_state_e;

  typedef enum logic [1:0] {p_idle, p_req, p_wait} port_state_e;

  // AR channel, id 0 is fetch and 1 is load
  typedef struct packed {
    logic        id;
    logic [31:0] addr;
  } rd_req_t;

  // R channel
  typedef struct packed {
    logic        id;
    logic [31:0] data;
    resp_e       resp;
  } rd_rsp_t;

endpackage

// File: design/insn_predecode.sv
// instruction pre-decode
// flags JAL and conditional branches, builds the JAL offset

`timescale 1ns/10ps

module insn_predecode
  import fetch_pkg::*;
(
  input  logic [31:0] insn,
  output logic        jal,
  output logic        branch,
  output logic [31:0] jal_target_off
);

  opcode_e opcode;

  assign opcode = opcode_e'(insn[6:0]);

  assign jal    = (opcode == op_jal);
  assign branch = (opcode == op_branch);

  // J-immediate, bit 0 always zero
  assign jal_target_off = {
    {12{insn[31]}},
    insn[19:12],
    insn[20],
    insn[30:21],
    1'b0
  };

endmodule

// File: design/ifu.sv
// instruction fetch unit
// one read per word, JAL redirect from pre-decode, external redirect has priority

`timescale 1ns/10ps

module ifu
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_update,
  input  logic [31:0] pc_in,
  output logic        fetch_ar_valid,
  input  logic        fetch_ar_ready,
  output logic [31:0] fetch_addr,
  input  logic        fetch_r_valid,
  output logic        fetch_r_ready,
  input  rd_rsp_t     fetch_rsp,
  output logic        instr_valid,
  output logic [31:0] instr,
  output logic [31:0] instr_pc,
  output logic        br,
  output logic        jal_taken,
  output logic        illegal
);

  fetch_state_e state, state_next;
  logic [31:0]  pc;  // redirect target while a fetch is in flight
  logic         stale;
  logic         ar_fire, r_fire, launch, drop, rsp_ok;
  logic         jal, branch;
  logic [31:0]  jal_off;
  logic [31:0]  launch_pc;

  insn_predecode u_predecode (
    .insn          (fetch_rsp.data),
    .jal           (jal),
    .branch        (branch),
    .jal_target_off(jal_off)
  );

  assign ar_fire        = fetch_ar_valid && fetch_ar_ready;
  assign r_fire         = (state == f_wait) && fetch_r_valid && fetch_r_ready;
  assign launch         = (state == f_idle) || r_fire;
  assign drop           = pc_update || stale;
  assign rsp_ok         = (fetch_rsp.resp == resp_okay);
  assign fetch_ar_valid = (state == f_req);

  always_comb begin
    state_next = state;
    case (state)
      f_idle:  state_next = f_req;
      f_req:   if (ar_fire) state_next = f_wait;
      f_wait:  if (r_fire) state_next = f_req;
      default: state_next = f_idle;
    endcase
  end

  // next fetch address, redirect first, then JAL, then pc+4
  always_comb begin
    if (pc_update) launch_pc = pc_in;
    else if (stale || state == f_idle) launch_pc = pc;
    else if (rsp_ok && jal) launch_pc = fetch_addr + jal_off;
    else launch_pc = fetch_addr + 32'd4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= f_idle;
      pc            <= reset_pc;
      stale         <= 1'b0;
      fetch_r_ready <= 1'b0;
    end else begin
      state         <= state_next;
      fetch_r_ready <= 1'b1;
      if (launch) begin
        pc    <= launch_pc;
        stale <= 1'b0;
      end else if (pc_update) begin
        pc    <= pc_in;
        stale <= 1'b1;  // request already out, drop its answer
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) fetch_addr <= launch_pc;
  end

  // decode-stage outputs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid <= 1'b0;
      instr       <= nop_insn;
      br          <= 1'b0;
      jal_taken   <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      instr_valid <= r_fire && !drop;
      instr       <= (r_fire && !drop && rsp_ok) ? fetch_rsp.data : nop_insn;
      br          <= r_fire && !drop && rsp_ok && branch;
      jal_taken   <= r_fire && !drop && rsp_ok && jal;
      illegal     <= r_fire && !drop && !rsp_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (r_fire) instr_pc <= fetch_addr;
  end

endmodule

// File: design/load_port.sv
// data load port
// turns a request strobe into one bus read, returns data or error

`timescale 1ns/10ps

module load_port
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ld_req,
  input  logic [31:0] ld_addr,
  output logic        ld_busy,
  output logic        ld_valid,
  output logic [31:0] ld_data,
  output logic        ld_err,
  output logic        ld_ar_valid,
  input  logic        ld_ar_ready,
  output logic [31:0] ld_ar_addr,
  input  logic        ld_r_valid,
  output logic        ld_r_ready,
  input  rd_rsp_t     ld_rsp
);

  port_state_e state;
  logic        start, r_fire;

  assign start       = ld_req && (state == p_idle);  // strobe while busy is ignored
  assign r_fire      = ld_r_valid && ld_r_ready;
  assign ld_busy     = (state != p_idle);
  assign ld_ar_valid = (state == p_req);
  assign ld_r_ready  = (state == p_wait);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= p_idle;
      ld_valid <= 1'b0;
      ld_err   <= 1'b0;
    end else begin
      ld_valid <= r_fire;
      case (state)
        p_idle:  if (start) state <= p_req;
        p_req:   if (ld_ar_ready) state <= p_wait;
        p_wait: begin
          if (r_fire) begin
            state  <= p_idle;
            ld_err <= (ld_rsp.resp != resp_okay);
          end
        end
        default: state <= p_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) ld_ar_addr <= ld_addr;
    if (r_fire) ld_data <= ld_rsp.data;
  end

endmodule

// File: design/read_arbiter.sv
// round-robin read arbiter
// two masters onto one AR/R bus, responses steered back by id

`timescale 1ns/10ps

module read_arbiter
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_ar_valid,
  output logic        fetch_ar_ready,
  input  logic [31:0] fetch_addr,
  output logic        fetch_r_valid,
  input  logic        fetch_r_ready,
  output rd_rsp_t     fetch_rsp,
  input  logic        ld_ar_valid,
  output logic        ld_ar_ready,
  input  logic [31:0] ld_addr,
  output logic        ld_r_valid,
  input  logic        ld_r_ready,
  output rd_rsp_t     ld_rsp,
  output logic        bus_ar_valid,
  input  logic        bus_ar_ready,
  output rd_req_t     bus_ar,
  input  logic        bus_r_valid,
  output logic        bus_r_ready,
  input  rd_rsp_t     bus_r
);

  logic last_grant;  // 1 = load
  logic locked;
  logic grant_q;
  logic grant;

  always_comb begin
    if (locked) grant = grant_q;
    else if (fetch_ar_valid && ld_ar_valid) grant = ~last_grant;
    else grant = ld_ar_valid;
  end

  assign bus_ar_valid   = grant ? ld_ar_valid : fetch_ar_valid;
  assign bus_ar.id      = grant;
  assign bus_ar.addr    = grant ? ld_addr : fetch_addr;
  assign fetch_ar_ready = !grant && bus_ar_ready;
  assign ld_ar_ready    = grant && bus_ar_ready;

  // grant held until the AR beat is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= 1'b1;  // fetch wins first
      locked     <= 1'b0;
      grant_q    <= 1'b0;
    end else if (bus_ar_valid && bus_ar_ready) begin
      last_grant <= grant;
      locked     <= 1'b0;
    end else if (bus_ar_valid) begin
      locked  <= 1'b1;
      grant_q <= grant;
    end
  end

  assign fetch_r_valid = bus_r_valid && !bus_r.id;
  assign ld_r_valid    = bus_r_valid && bus_r.id;
  assign fetch_rsp     = bus_r;
  assign ld_rsp        = bus_r;
  assign bus_r_ready   = bus_r.id ? ld_r_ready : fetch_r_ready;

endmodule

// File: design/boot_rom.sv
// boot ROM read slave
// single beat, fixed two-cycle latency, error above the ROM range

`timescale 1ns/10ps

module boot_rom
  import fetch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    bus_ar_valid,
  output logic    bus_ar_ready,
  input  rd_req_t bus_ar,
  output logic    bus_r_valid,
  input  logic    bus_r_ready,
  output rd_rsp_t bus_r
);

  logic [31:0] mem [rom_words];
  port_state_e state;
  logic        lat_cnt;
  rd_req_t     req_q;
  logic        in_range;

  initial $readmemh("program.hex", mem);

  assign bus_ar_ready = (state == p_idle);
  assign bus_r_valid  = (state == p_wait);
  assign in_range     = (req_q.addr < 32'(4 * rom_words));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= p_idle;
      lat_cnt <= 1'b0;
    end else begin
      case (state)
        p_idle: begin
          if (bus_ar_valid) begin
            state   <= p_req;
            lat_cnt <= 1'b0;
          end
        end
        p_req: begin
          lat_cnt <= 1'b1;
          if (lat_cnt) state <= p_wait;  // second cycle after accept
        end
        p_wait:  if (bus_r_ready) state <= p_idle;
        default: state <= p_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus_ar_valid && bus_ar_ready) req_q <= bus_ar;
    if (state == p_req && lat_cnt) begin
      bus_r.id   <= req_q.id;
      bus_r.data <= in_range ? mem[req_q.addr[$clog2(rom_words)+1:2]] : 32'h0;
      bus_r.resp <= in_range ? resp_okay : resp_slverr;
    end
  end

endmodule

// File: design/fetch_top.sv
// fetch subsystem top
// fetch unit and load port share the boot ROM through the arbiter

`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_update,
  input  logic [31:0] pc_in,
  output logic        instr_valid,
  output logic [31:0] instr,
  output logic [31:0] instr_pc,
  output logic        br,
  output logic        jal_taken,
  output logic        illegal,
  input  logic        ld_req,
  input  logic [31:0] ld_addr,
  output logic        ld_busy,
  output logic        ld_valid,
  output logic [31:0] ld_data,
  output logic        ld_err
);

  logic        fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
  logic [31:0] fetch_addr;
  rd_rsp_t     fetch_rsp;
  logic        ld_ar_valid, ld_ar_ready, ld_r_valid, ld_r_ready;
  logic [31:0] ld_ar_addr;
  rd_rsp_t     ld_rsp;
  logic        bus_ar_valid, bus_ar_ready, bus_r_valid, bus_r_ready;
  rd_req_t     bus_ar;
  rd_rsp_t     bus_r;

  ifu u_ifu (
    .clk, .rst_n, .pc_update, .pc_in,
    .fetch_ar_valid, .fetch_ar_ready, .fetch_addr,
    .fetch_r_valid, .fetch_r_ready, .fetch_rsp,
    .instr_valid, .instr, .instr_pc, .br, .jal_taken, .illegal
  );

  load_port u_load_port (
    .clk, .rst_n, .ld_req, .ld_addr, .ld_busy, .ld_valid, .ld_data, .ld_err,
    .ld_ar_valid, .ld_ar_ready, .ld_ar_addr,
    .ld_r_valid, .ld_r_ready, .ld_rsp
  );

  read_arbiter u_arbiter (
    .clk, .rst_n,
    .fetch_ar_valid, .fetch_ar_ready, .fetch_addr,
    .fetch_r_valid, .fetch_r_ready, .fetch_rsp,
    .ld_ar_valid, .ld_ar_ready, .ld_addr(ld_ar_addr),
    .ld_r_valid, .ld_r_ready, .ld_rsp,
    .bus_ar_valid, .bus_ar_ready, .bus_ar,
    .bus_r_valid, .bus_r_ready, .bus_r
  );

  boot_rom u_rom (
    .clk, .rst_n, .bus_ar_valid, .bus_ar_ready, .bus_ar,
    .bus_r_valid, .bus_r_ready, .bus_r
  );

endmodule

// File: tb/tb_fetch_top.sv
// testbench for the fetch subsystem
// fetch stream, redirects and load port checked against a reference model

`timescale 1ns/10ps

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int aw = $clog2(rom_words);

  typedef struct packed {
    logic [31:0] instr;
    logic        br;
    logic        jal;
    logic        illegal;
    logic [31:0] next_pc;
  } fetch_exp_t;

  typedef struct packed {
    logic        err;
    logic [31:0] data;
  } load_exp_t;

  logic        clk, rst_n, pc_update, ld_req;
  logic [31:0] pc_in, ld_addr;
  logic        instr_valid, br, jal_taken, illegal, ld_busy, ld_valid, ld_err;
  logic [31:0] instr, instr_pc, ld_data;

  logic [31:0] rom_img [rom_words];
  load_exp_t   load_q [$];
  logic [31:0] exp_pc = reset_pc;
  logic [31:0] last_pc = 32'h0;
  int beat_count = 0;
  int load_count = 0;
  int br_count = 0;
  int jal_count = 0;
  int illegal_count = 0;
  int error_count = 0;
  int check_count = 0;
  int test_base = 0;
  bit timeout_hit = 1'b0;
  int seed = 39408;

  fetch_top DUT (.*);

  always #5 clk = ~clk;

  function automatic fetch_exp_t expect_fetch(input logic [31:0] pc, input logic redirect,
                                              input logic [31:0] redirect_pc);
    fetch_exp_t  e;
    logic [31:0] word;
    logic [31:0] j_imm;
    e.br      = 1'b0;
    e.jal     = 1'b0;
    e.illegal = 1'b0;
    j_imm     = 32'h0;
    if (pc < 4 * rom_words) begin
      word    = rom_img[pc[aw+1:2]];
      e.instr = word;
      e.br    = (word[6:0] == 7'b1100011);
      e.jal   = (word[6:0] == 7'b1101111);
      j_imm   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    end else begin
      e.instr   = nop_insn;  // bus error
      e.illegal = 1'b1;
    end
    if (redirect) e.next_pc = redirect_pc;
    else if (e.jal) e.next_pc = pc + j_imm;
    else e.next_pc = pc + 32'd4;
    return e;
  endfunction

  function automatic load_exp_t expect_load(input logic [31:0] addr);
    load_exp_t l;
    if (addr < 4 * rom_words) begin
      l.err  = 1'b0;
      l.data = rom_img[addr[aw+1:2]];
    end else begin
      l.err  = 1'b1;
      l.data = 32'h0;
    end
    return l;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s", what);
    timeout_hit = 1'b1;
    error_count++;
  endtask

  task automatic wait_beats(input int target, input string what);
    int n;
    n = 0;
    while (beat_count < target && n < 500 && !timeout_hit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (beat_count < target) report_timeout(what);
  endtask

  task automatic wait_loads(input int target);
    int n;
    n = 0;
    while (load_count < target && n < 300 && !timeout_hit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (load_count < target) report_timeout("ld_valid of a load");
  endtask

  task automatic issue_load(input logic [31:0] addr);
    int n;
    int target;
    n = 0;
    while (ld_busy && n < 300 && !timeout_hit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ld_busy) report_timeout("load port to go idle");
    target  = load_count + 1;
    ld_req  = 1'b1;
    ld_addr = addr;
    load_q.push_back(expect_load(addr));
    @(posedge clk);
    #1;
    assert (ld_busy) else begin
      $display("ld_busy did not rise after the ld_req strobe");
      error_count++;
    end
    @(posedge clk);  // second strobe cycle lands while busy
    #1;
    ld_req = 1'b0;
    wait_loads(target);
  endtask

  task automatic end_test(input string name);
    $display("test %-18s %s, %0d errors", name,
             (error_count == test_base) ? "ok" : "failed", error_count - test_base);
    test_base = error_count;
  endtask

  // every beat checked on the falling edge
  always @(negedge clk) begin : monitor
    fetch_exp_t e;
    load_exp_t  l;
    if (rst_n) begin
      if (instr_valid) begin
        e = expect_fetch(exp_pc, pc_update, pc_in);
        compare_field("instr_pc", instr_pc, exp_pc);
        compare_field("instr", instr, e.instr);
        compare_field("br", 32'(br), 32'(e.br));
        compare_field("jal_taken", 32'(jal_taken), 32'(e.jal));
        compare_field("illegal", 32'(illegal), 32'(e.illegal));
        exp_pc  = e.next_pc;
        last_pc = instr_pc;
        beat_count++;
        if (br) br_count++;
        if (jal_taken) jal_count++;
        if (illegal) illegal_count++;
      end else if (pc_update) begin
        exp_pc = pc_in;  // word in flight is dropped
      end
      if (ld_valid) begin
        assert (load_q.size() > 0) else begin
          $display("ld_valid pulsed with no load outstanding");
          error_count++;
        end
        if (load_q.size() > 0) begin
          l = load_q.pop_front();
          compare_field("ld_data", ld_data, l.data);
          compare_field("ld_err", 32'(ld_err), 32'(l.err));
        end
        load_count++;
      end
    end
  end

  initial begin
    logic [31:0] target;
    int          gap;
    int          base;
    fetch_exp_t  jal_exp;
    clk       = 1'b0;
    rst_n     = 1'b0;
    pc_update = 1'b0;
    pc_in     = 32'h0;
    ld_req    = 1'b0;
    ld_addr   = 32'h0;
    $readmemh("program.hex", rom_img);
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    wait_beats(5, "the first five fetched words");
    assert (br_count == 1) else begin
      $display("branch flag seen %0d times in the first five words", br_count);
      error_count++;
    end
    end_test("straight code");

    wait_beats(7, "the word at the JAL target");
    assert (jal_count == 1) else begin
      $display("jal_taken seen %0d times, one expected", jal_count);
      error_count++;
    end
    jal_exp = expect_fetch(32'h14, 1'b0, 32'h0);
    compare_field("instr_pc", last_pc, jal_exp.next_pc);
    end_test("jal redirect");

    wait_beats(14, "fetches past the ROM");
    assert (illegal_count >= 3) else begin
      $display("only %0d illegal words after the jump out of the ROM", illegal_count);
      error_count++;
    end
    end_test("jal out of range");

    for (int i = 0; i < 4; i++) begin
      target = $random(seed) & 32'h0000_00fc;
      gap    = $random(seed) & 7;
      repeat (gap) @(posedge clk);  // vary the FSM phase of the redirect
      @(posedge clk);
      #1;
      pc_update = 1'b1;
      pc_in     = target;
      @(posedge clk);
      #1;
      pc_update = 1'b0;
      base      = beat_count;
      wait_beats(base + 1, "the first word after pc_update");
      compare_field("instr_pc", last_pc, target);
    end
    end_test("pc_update");

    base = beat_count;
    issue_load(32'h0000_00fc);
    issue_load(32'h0000_0100);
    for (int i = 0; i < 6; i++) begin
      issue_load($random(seed) & 32'h0000_01fc);
    end
    assert (beat_count > base && load_q.size() == 0) else begin
      $display("fetch stalled or loads left unanswered while loads ran");
      error_count++;
    end
    end_test("loads during fetch");

    $display("tests 5, checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: fetch_sub.f
design/fetch_pkg.sv
design/insn_predecode.sv
design/ifu.sv
design/load_port.sv
design/read_arbiter.sv
design/boot_rom.sv
design/fetch_top.sv
tb/tb_fetch_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch subsystem testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_fetch_top -f fetch_sub.f -o sim_fetch
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fetch > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
  exit 1
fi
exit 0

// File: program.hex
// boot ROM image, 64 instruction words, eight per line
// word address rises left to right, line by line from word 0
00000013 00100093 00208113 00208463 00000013 01c0006f 00000013 00000013
00000013 00000013 00000013 00000013 00308193 00418213 00208463 00000013
1000006f 00108093 00208093 00308093 00408093 00508093 00608093 00708093
00808093 00908093 00a08093 00b08093 fe209ee3 00c08093 00d08093 00e08093
00f08093 01008093 01108093 01208093 01308093 01408093 01508093 01608093
01708093 01808093 01908093 01a08093 fe209ee3 01b08093 01c08093 01d08093
01e08093 01f08093 02008093 02108093 02208093 02308093 02408093 02508093
02608093 02708093 02808093 02908093 02a08093 02b08093 02c08093 02d08093
